// File: alu_cfg_pkg.sv
/*
 * Datapath width configuration for the execute unit.
 * Modules take their xlen default and shift-amount width from here.
 */
`default_nettype none

package alu_cfg_pkg;

    // datapath width unless the top level overrides it
    localparam int default_xlen = 64;

    // shift amount width is log2 of the datapath width
    function automatic int shamt_bits(input int width);
        return $clog2(width);
    endfunction

endpackage

`default_nettype wire

// File: alu_op_pkg.sv
/*
 * Operation encoding for the execute unit. The 5-bit op word is read
 * either as an ALU function or as a multiply form, selected by its class bit.
 */
`default_nettype none

package alu_op_pkg;

    localparam int op_bits = 5;

    typedef enum logic {
        cls_alu = 1'b0,
        cls_mul = 1'b1
    } op_class_e;

    typedef enum logic [3:0] {
        fn_add    = 4'd0,
        fn_sub    = 4'd1,
        fn_slt    = 4'd2,
        fn_sltu   = 4'd3,
        fn_and    = 4'd4,
        fn_or     = 4'd5,
        fn_xor    = 4'd6,
        fn_sll    = 4'd7,
        fn_srl    = 4'd8,
        fn_sra    = 4'd9,
        fn_pass_b = 4'd10
    } alu_fn_e;

    // operand signedness with the upper bit for a and the lower bit for b
    typedef enum logic [1:0] {
        mm_uu = 2'b00,
        mm_su = 2'b10,
        mm_ss = 2'b11
    } mul_mode_e;

    typedef struct packed {
        op_class_e cls;
        alu_fn_e   fn;
    } alu_view_t;

    // mul = low half mm_ss, mulh/mulhsu/mulhu = high half with ss/su/uu
    typedef struct packed {
        op_class_e cls;
        logic      mul_hi;
        mul_mode_e mode;
        logic      spare;
    } mul_view_t;

    typedef union packed {
        alu_view_t alu;
        mul_view_t mul;
    } op_word_u;

endpackage

`default_nettype wire

// File: mul_if.sv
/*
 * Link between the op sequencer and the iterative multiplier.
 * The sequencer loads operands and steps, the multiplier returns both halves.
 */
`default_nettype none

interface mul_if #(
    parameter int xlen = alu_cfg_pkg::default_xlen
);
    import alu_op_pkg::*;

    logic             load;
    logic             step;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    mul_mode_e        mode;
    logic [xlen-1:0]  prod_hi;
    logic [xlen-1:0]  prod_lo;

    modport seq (output load, step, a, b, mode, input prod_hi, prod_lo);

    modport mul (input load, step, a, b, mode, output prod_hi, prod_lo);

endinterface

`default_nettype wire

// File: barrel_shifter.sv
/*
 * Combinational shifter for sll, srl and sra. Left shifts reuse the
 * right shifter by reversing the bit order before and after.
 */
`default_nettype none

module barrel_shifter #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire logic [xlen-1:0]                            din,
    input  wire logic [alu_cfg_pkg::shamt_bits(xlen)-1:0]   shamt,
    input  wire logic                                       left,
    input  wire logic                                       arith,
    output logic      [xlen-1:0]                            dout
);

    logic [xlen-1:0]         src;
    logic signed [xlen:0]    src_ext;
    logic signed [xlen:0]    shr;

    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            src[i] = left ? din[xlen-1-i] : din[i];
        end
    end

    // sign fill only for sra
    assign src_ext = {arith & src[xlen-1], src};
    assign shr     = src_ext >>> shamt;

    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            dout[i] = left ? shr[xlen-1-i] : shr[i];
        end
    end

endmodule

`default_nettype wire

// File: int_alu.sv
/*
 * Single-cycle integer ALU. Result, less and zero are combinational
 * from the ALU view of the op word and the two operands.
 */
`default_nettype none

module int_alu #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire alu_op_pkg::op_word_u  op,
    input  wire logic [xlen-1:0]       a,
    input  wire logic [xlen-1:0]       b,
    output logic      [xlen-1:0]       result,
    output logic                       less,
    output logic                       zero
);
    import alu_op_pkg::*;
    import alu_cfg_pkg::*;

    localparam int sb = shamt_bits(xlen);

    alu_fn_e          fn;
    logic             sub;
    logic [xlen-1:0]  b_x;
    logic [xlen:0]    sum_ext;
    logic [xlen-1:0]  sum;
    logic             carry;
    logic             overflow;
    logic [xlen-1:0]  shift_out;

    assign fn = op.alu.fn;

    // everything but add runs the a - b compare
    assign sub = (fn != fn_add);
    assign b_x = b ^ {xlen{sub}};

    assign sum_ext = {1'b0, a} + {1'b0, b_x} + (xlen + 1)'(sub);
    assign sum     = sum_ext[xlen-1:0];
    assign carry   = sum_ext[xlen];

    assign overflow = (a[xlen-1] == b_x[xlen-1]) && (a[xlen-1] != sum[xlen-1]);
    assign less     = (fn == fn_sltu) ? (carry ^ sub) : (overflow ^ sum[xlen-1]);
    assign zero     = (sum == '0);

    barrel_shifter #(
        .xlen   (xlen)
    ) u_shifter (
        .din    (a),
        .shamt  (b[sb-1:0]),
        .left   (fn == fn_sll),
        .arith  (fn == fn_sra),
        .dout   (shift_out)
    );

    // ========================================================================
    // result select
    // ========================================================================
    always_comb begin
        unique case (fn)
            fn_add, fn_sub:         result = sum;
            fn_slt, fn_sltu:        result = {{(xlen - 1){1'b0}}, less};
            fn_and:                 result = a & b;
            fn_or:                  result = a | b;
            fn_xor:                 result = a ^ b;
            fn_sll, fn_srl, fn_sra: result = shift_out;
            fn_pass_b:              result = b;
            default:                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: step_counter.sv
/*
 * Counts the multiplier steps. Loaded with xlen on start_count and
 * flags the cycle of the final step with last.
 */
`default_nettype none

module step_counter #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  start_count,
    output logic       last
);

    localparam int cw = $clog2(xlen + 1);

    logic [cw-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start_count) begin
            count <= cw'(xlen);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // one step left
    assign last = (count == cw'(1));

endmodule

`default_nettype wire

// File: shift_add_multiplier.sv
/*
 * Iterative sign-magnitude multiplier, one multiplier bit per step.
 * After xlen steps both halves of the signed product are on the interface.
 */
`default_nettype none

module shift_add_multiplier #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    mul_if.mul         mul
);
    import alu_op_pkg::*;

    logic                 a_signed;
    logic                 b_signed;
    logic                 a_neg;
    logic                 b_neg;
    logic                 neg_q;
    logic [xlen-1:0]      mcand;
    logic [xlen-1:0]      mplier;
    logic [2*xlen-1:0]    acc;
    logic [xlen:0]        partial;
    logic [2*xlen-1:0]    prod;

    assign a_signed = (mul.mode == mm_ss) || (mul.mode == mm_su);
    assign b_signed = (mul.mode == mm_ss);
    assign a_neg    = a_signed && mul.a[xlen-1];
    assign b_neg    = b_signed && mul.b[xlen-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            neg_q <= 1'b0;
        end else if (mul.load) begin
            neg_q <= a_neg ^ b_neg;
        end
    end

    // ========================================================================
    // magnitude datapath
    // ========================================================================
    // add into the upper half, then shift the whole accumulator right
    assign partial = {1'b0, acc[2*xlen-1:xlen]} + {1'b0, (mplier[0] ? mcand : '0)};

    always_ff @(posedge clk) begin
        if (mul.load) begin
            mcand  <= a_neg ? -mul.a : mul.a;
            mplier <= b_neg ? -mul.b : mul.b;
            acc    <= '0;
        end else if (mul.step) begin
            mplier <= mplier >> 1;
            acc    <= {partial, acc[xlen-1:1]};
        end
    end

    // back to two's complement
    assign prod = neg_q ? -acc : acc;

    assign mul.prod_hi = prod[2*xlen-1:xlen];
    assign mul.prod_lo = prod[xlen-1:0];

endmodule

`default_nettype wire

// File: op_sequencer.sv
/*
 * Handshake control for the execute unit. ALU results are registered on
 * acceptance, multiplies run through load, step and capture states.
 */
`default_nettype none

module op_sequencer #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            in_valid,
    output logic                                 in_ready,
    input  wire logic [alu_op_pkg::op_bits-1:0]  op,
    input  wire logic [xlen-1:0]                 a,
    input  wire logic [xlen-1:0]                 b,
    output logic                                 out_valid,
    input  wire logic                            out_ready,
    output logic      [xlen-1:0]                 result,
    output logic                                 less,
    output logic                                 zero,
    output alu_op_pkg::op_word_u                 alu_op,
    output logic      [xlen-1:0]                 alu_a,
    output logic      [xlen-1:0]                 alu_b,
    input  wire logic [xlen-1:0]                 alu_result,
    input  wire logic                            alu_less,
    input  wire logic                            alu_zero,
    output logic                                 start_count,
    input  wire logic                            last,
    mul_if.seq                                   mul
);
    import alu_op_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_mul_run,
        st_mul_done
    } state_e;

    state_e           state;
    op_word_u         op_w;
    logic             accept;
    logic             take_alu;
    logic             take_mul;
    logic             load_q;
    logic             mul_hi_q;
    logic [xlen-1:0]  op_a_q;
    logic [xlen-1:0]  op_b_q;
    mul_mode_e        mode_q;

    assign op_w     = op;
    assign in_ready = (state == st_idle) && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;
    assign take_alu = accept && (op_w.alu.cls == cls_alu);
    assign take_mul = accept && (op_w.alu.cls == cls_mul);

    // ALU sees the raw input every cycle
    assign alu_op = op_w;
    assign alu_a  = a;
    assign alu_b  = b;

    assign mul.load = load_q;
    assign mul.step = (state == st_mul_run) && !load_q;
    assign mul.a    = op_a_q;
    assign mul.b    = op_b_q;
    assign mul.mode = mode_q;

    // ========================================================================
    // state machine
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            load_q      <= 1'b0;
            start_count <= 1'b0;
            mul_hi_q    <= 1'b0;
        end else begin
            load_q      <= 1'b0;
            start_count <= 1'b0;
            unique case (state)
                st_idle: begin
                    if (take_mul) begin
                        state       <= st_mul_run;
                        load_q      <= 1'b1;
                        start_count <= 1'b1;
                        mul_hi_q    <= op_w.mul.mul_hi;
                    end
                end
                st_mul_run: begin
                    if (last) begin
                        state <= st_mul_done;
                    end
                end
                st_mul_done: state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_mul) begin
            op_a_q <= a;
            op_b_q <= b;
            mode_q <= op_w.mul.mode;
        end
    end

    // output slot held until out_ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            less      <= 1'b0;
            zero      <= 1'b0;
        end else if (state == st_mul_done) begin
            out_valid <= 1'b1;
            result    <= mul_hi_q ? mul.prod_hi : mul.prod_lo;
            less      <= 1'b0;
            zero      <= 1'b0;
        end else if (take_alu) begin
            out_valid <= 1'b1;
            result    <= alu_result;
            less      <= alu_less;
            zero      <= alu_zero;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: alu_top.sv
/*
 * Integer execute unit with valid/ready on both sides.
 * Connects the sequencer, ALU, step counter and multiplier.
 */
`default_nettype none

module alu_top #(
    parameter int xlen = alu_cfg_pkg::default_xlen
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            in_valid,
    output logic                                 in_ready,
    input  wire logic [alu_op_pkg::op_bits-1:0]  op,
    input  wire logic [xlen-1:0]                 a,
    input  wire logic [xlen-1:0]                 b,
    output logic                                 out_valid,
    input  wire logic                            out_ready,
    output logic      [xlen-1:0]                 result,
    output logic                                 less,
    output logic                                 zero
);
    import alu_op_pkg::*;

    op_word_u         alu_op;
    logic [xlen-1:0]  alu_a;
    logic [xlen-1:0]  alu_b;
    logic [xlen-1:0]  alu_result;
    logic             alu_less;
    logic             alu_zero;
    logic             start_count;
    logic             last;

    mul_if #(.xlen(xlen)) u_mul_if ();

    op_sequencer #(
        .xlen        (xlen)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .op          (op),
        .a           (a),
        .b           (b),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .result      (result),
        .less        (less),
        .zero        (zero),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .alu_less    (alu_less),
        .alu_zero    (alu_zero),
        .start_count (start_count),
        .last        (last),
        .mul         (u_mul_if.seq)
    );

    int_alu #(
        .xlen   (xlen)
    ) u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (alu_less),
        .zero   (alu_zero)
    );

    step_counter #(
        .xlen        (xlen)
    ) u_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_count (start_count),
        .last        (last)
    );

    shift_add_multiplier #(
        .xlen  (xlen)
    ) u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (u_mul_if.mul)
    );

endmodule

`default_nettype wire

// File: tb_alu_model.svh
/*
 * Reference model for the execute unit testbench, included inside the
 * testbench module and sized by its xlen.
 */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// result of one ALU function with the shift amount from the low bits of y
function automatic logic [xlen-1:0] alu_reference(input alu_fn_e fn,
                                                  input logic [xlen-1:0] x,
                                                  input logic [xlen-1:0] y);
    logic [$clog2(xlen)-1:0] sh;
    logic [xlen-1:0]         r;
    sh = y[$clog2(xlen)-1:0];
    case (fn)
        fn_add:    r = x + y;
        fn_sub:    r = x - y;
        fn_slt:    r = ($signed(x) < $signed(y)) ? xlen'(1) : '0;
        fn_sltu:   r = (x < y) ? xlen'(1) : '0;
        fn_and:    r = x & y;
        fn_or:     r = x | y;
        fn_xor:    r = x ^ y;
        fn_sll:    r = x << sh;
        fn_srl:    r = x >> sh;
        fn_sra:    r = $signed(x) >>> sh;
        fn_pass_b: r = y;
        default:   r = '0;
    endcase
    return r;
endfunction

// add reports the true sign of a + b and the rest compare a with b
function automatic logic flag_less(input alu_fn_e fn,
                                   input logic [xlen-1:0] x,
                                   input logic [xlen-1:0] y);
    logic [xlen:0] wide_sum;
    wide_sum = {x[xlen-1], x} + {y[xlen-1], y};
    if (fn == fn_add) begin
        return wide_sum[xlen];
    end
    if (fn == fn_sltu) begin
        return x < y;
    end
    return $signed(x) < $signed(y);
endfunction

function automatic logic flag_zero(input alu_fn_e fn,
                                   input logic [xlen-1:0] x,
                                   input logic [xlen-1:0] y);
    logic [xlen-1:0] s;
    s = x + y;
    if (fn == fn_add) begin
        return s == '0;
    end
    return x == y;
endfunction

// full double-width product of operands extended by signedness
function automatic logic [2*xlen-1:0] wide_product(input mul_mode_e mode,
                                                   input logic [xlen-1:0] x,
                                                   input logic [xlen-1:0] y);
    logic [2*xlen-1:0] xe;
    logic [2*xlen-1:0] ye;
    xe = {{xlen{x[xlen-1] & (mode != mm_uu)}}, x};
    ye = {{xlen{y[xlen-1] & (mode == mm_ss)}}, y};
    return xe * ye;
endfunction

`endif

// File: tb_alu_top.sv
/*
 * Testbench for the execute unit. Random ALU and multiply operations, some
 * under random back-pressure, are checked in order against a model.
 */
`default_nettype none

module tb_alu_top;
    import alu_op_pkg::*;

    localparam int xlen      = 64;
    localparam int n_alu     = 400;
    localparam int n_mul     = 40;
    localparam int n_stream  = 64;
    localparam int n_mixed   = 300;
    localparam int total_ops = n_alu + n_mul + n_stream + n_mixed;
    localparam longint timeout = longint'(total_ops) * (xlen + 4) * 20 + 40000;

    `include "tb_alu_model.svh"

    typedef struct packed {
        logic [xlen-1:0] result;
        logic            less;
        logic            zero;
        logic            is_mul;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    logic [op_bits-1:0] op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
    logic              out_valid;
    logic              out_ready;
    logic [xlen-1:0]   result;
    logic              less;
    logic              zero;

    expect_t           exp_q[$];
    int                accept_q[$];
    int                edge_count = 0;
    int                accept_count = 0;
    int                n_errors = 0;
    int                n_checks = 0;
    int                n_tests = 0;
    int                n_failed = 0;
    int                test_err_start = 0;
    int                test_ops = 0;
    bit                backpressure = 1'b0;
    bit                check_latency = 1'b0;
    bit                hold_pending = 1'b0;
    logic [xlen-1:0]   held_result;
    logic              held_less;
    logic              held_zero;

    alu_top #(
        .xlen      (xlen)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .less      (less),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(timeout);
        $display("timeout: the run did not finish, an operation or result is stuck");
        $display("Test FAILED");
        $finish;
    end

    // ========================================================================
    // monitor of both handshakes on pre-edge values
    // ========================================================================
    always @(posedge clk) begin : monitor
        op_word_u          w;
        expect_t           item;
        logic [2*xlen-1:0] prod;
        int                acc_edge;
        int                want;
        edge_count++;
        if (rst_n) begin
            if (hold_pending) begin
                if (!out_valid) begin
                    $display("error: time %0t, out_valid dropped before the result was taken",
                             $time);
                    n_errors++;
                end else begin
                    if (result !== held_result) begin
                        $display("error: time %0t, held result: expected %h, got %h",
                                 $time, held_result, result);
                        n_errors++;
                    end
                    if ({less, zero} !== {held_less, held_zero}) begin
                        $display("error: time %0t, held less/zero: expected %b%b, got %b%b",
                                 $time, held_less, held_zero, less, zero);
                        n_errors++;
                    end
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("error: time %0t, a result came out with no operation pending",
                             $time);
                    n_errors++;
                end else begin
                    item     = exp_q.pop_front();
                    acc_edge = accept_q.pop_front();
                    n_checks++;
                    if (result !== item.result) begin
                        $display("error: time %0t, result: expected %h, got %h",
                                 $time, item.result, result);
                        n_errors++;
                    end
                    if (less !== item.less) begin
                        $display("error: time %0t, less: expected %b, got %b",
                                 $time, item.less, less);
                        n_errors++;
                    end
                    if (zero !== item.zero) begin
                        $display("error: time %0t, zero: expected %b, got %b",
                                 $time, item.zero, zero);
                        n_errors++;
                    end
                    // transfer comes one edge after out_valid rises
                    if (check_latency) begin
                        want = item.is_mul ? xlen + 3 : 1;
                        if (edge_count - acc_edge != want) begin
                            $display("error: time %0t, latency: expected %0d, got %0d",
                                     $time, want, edge_count - acc_edge);
                            n_errors++;
                        end
                    end
                end
            end
            hold_pending = out_valid && !out_ready;
            if (hold_pending) begin
                held_result = result;
                held_less   = less;
                held_zero   = zero;
                if (in_ready !== 1'b0) begin
                    $display("error: time %0t, in_ready: expected 0, got %b", $time, in_ready);
                    n_errors++;
                end
            end
            if (in_valid && in_ready) begin
                w = op;
                if (w.alu.cls == cls_alu) begin
                    item.result = alu_reference(w.alu.fn, a, b);
                    item.less   = flag_less(w.alu.fn, a, b);
                    item.zero   = flag_zero(w.alu.fn, a, b);
                    item.is_mul = 1'b0;
                end else begin
                    prod        = wide_product(w.mul.mode, a, b);
                    item.result = w.mul.mul_hi ? prod[2*xlen-1:xlen] : prod[xlen-1:0];
                    item.less   = 1'b0;
                    item.zero   = 1'b0;
                    item.is_mul = 1'b1;
                end
                exp_q.push_back(item);
                accept_q.push_back(edge_count);
                accept_count++;
            end
        end
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================
    task automatic next_cycle();
        @(negedge clk);
        if (backpressure) begin
            out_ready = ($urandom_range(99, 0) < 60);
        end else begin
            out_ready = 1'b1;
        end
    endtask

    function automatic logic [xlen-1:0] random_operand();
        case ($urandom_range(7, 0))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(xlen - 1){1'b0}}};
            3:       return xlen'(1);
            default: return xlen'({$urandom, $urandom});
        endcase
    endfunction

    function automatic op_word_u random_alu_op();
        op_word_u w;
        w        = '0;
        w.alu.cls = cls_alu;
        w.alu.fn  = alu_fn_e'($urandom_range(10, 0));
        return w;
    endfunction

    // mul, mulh, mulhsu, mulhu
    function automatic op_word_u random_mul_op();
        op_word_u w;
        w         = '0;
        w.mul.cls = cls_mul;
        case ($urandom_range(3, 0))
            0: begin
                w.mul.mul_hi = 1'b0;
                w.mul.mode   = mm_ss;
            end
            1: begin
                w.mul.mul_hi = 1'b1;
                w.mul.mode   = mm_ss;
            end
            2: begin
                w.mul.mul_hi = 1'b1;
                w.mul.mode   = mm_su;
            end
            default: begin
                w.mul.mul_hi = 1'b1;
                w.mul.mode   = mm_uu;
            end
        endcase
        w.mul.spare = 1'($urandom_range(1, 0));
        return w;
    endfunction

    // holds the op until accepted and counts the edges it took in waited
    task automatic send_op(input op_word_u w, input logic [xlen-1:0] op_a,
                           input logic [xlen-1:0] op_b, output int waited);
        int target;
        target   = accept_count + 1;
        waited   = 0;
        in_valid = 1'b1;
        op       = w;
        a        = op_a;
        b        = op_b;
        do begin
            next_cycle();
            waited++;
        end while (accept_count < target);
        in_valid = 1'b0;
        test_ops++;
    endtask

    task automatic send_random(input bit mul_op, output int waited);
        op_word_u        w;
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
        w    = mul_op ? random_mul_op() : random_alu_op();
        op_a = random_operand();
        op_b = random_operand();
        send_op(w, op_a, op_b, waited);
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic close_test(input string name);
        int errs;
        errs = n_errors - test_err_start;
        n_tests++;
        if (errs != 0) begin
            n_failed++;
        end
        $display("%s: %0d ops, %0d errors, %s", name, test_ops, errs,
                 (errs == 0) ? "pass" : "fail");
        test_err_start = n_errors;
        test_ops       = 0;
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin : main
        int waited;
        bit prev_alu;
        bit is_mul;
        void'($urandom(32'hafee5c72));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        op        = '0;
        a         = '0;
        b         = '0;
        out_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("error: time %0t, out_valid: expected 0, got %b", $time, out_valid);
            n_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("error: time %0t, in_ready: expected 1, got %b", $time, in_ready);
            n_errors++;
        end
        if ({result, less, zero} !== '0) begin
            $display("error: time %0t, result/less/zero: expected 0, got %h/%b/%b",
                     $time, result, less, zero);
            n_errors++;
        end
        close_test("reset");

        next_cycle();
        for (int i = 0; i < n_alu; i++) begin
            send_random(1'b0, waited);
        end
        drain_results();
        close_test("alu_random");

        for (int i = 0; i < n_mul; i++) begin
            send_random(1'b1, waited);
        end
        drain_results();
        close_test("mul_random");

        // back-to-back ALU ops with a multiply every 16th slot
        check_latency = 1'b1;
        prev_alu      = 1'b0;
        for (int i = 0; i < n_stream; i++) begin
            is_mul = (i % 16 == 15);
            send_random(is_mul, waited);
            if (!is_mul && prev_alu && waited != 1) begin
                $display("error: time %0t, an ALU op waited %0d cycles after another ALU op",
                         $time, waited);
                n_errors++;
            end
            prev_alu = !is_mul;
        end
        drain_results();
        check_latency = 1'b0;
        close_test("stream_timing");

        backpressure = 1'b1;
        for (int i = 0; i < n_mixed; i++) begin
            if ($urandom_range(99, 0) < 20) begin
                repeat ($urandom_range(3, 1)) next_cycle();
            end
            is_mul = ($urandom_range(99, 0) < 15);
            send_random(is_mul, waited);
        end
        drain_results();
        backpressure = 1'b0;
        // nothing more may come out
        repeat (4) next_cycle();
        close_test("mixed_backpressure");

        $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
alu_cfg_pkg.sv
alu_op_pkg.sv
mul_if.sv
barrel_shifter.sv
int_alu.sv
step_counter.sv
shift_add_multiplier.sv
op_sequencer.sv
alu_top.sv
tb_alu_top.sv

// File: Makefile
# Verilator simulation of the execute unit testbench

TOP := tb_alu_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, output in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
